//--- include/mcu_consts.svh
// ****************************************
// MCU memory and interrupt constants
// ****************************************
`ifndef MCU_CONSTS_SVH
`define MCU_CONSTS_SVH

// RAM organisation
`define NUM_BANKS 4
`define BANK_WORDS 64

// Bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define BE_WIDTH 4

// Core interrupt vector positions
`define IRQ_SOFTWARE_BIT 3
`define IRQ_TIMER_BIT 7
`define IRQ_EXTERNAL_BIT 11
`define IRQ_FAST_LSB 16

// Fast field and always-on GPIO lines
`define NUM_FAST_IRQ 15
`define NUM_GPIO_IRQ 8

`endif

//--- verilog/mcu_bus_pkg.sv
// ****************************************
// Bus field types for the banked RAM
// ****************************************
`include "mcu_consts.svh"

package mcu_bus_pkg;

  // Byte address as seen by the master
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  typedef logic [`DATA_WIDTH-1:0] data_t;

  typedef logic [`BE_WIDTH-1:0] be_t;

  // Which bank a request lands in
  typedef logic [$clog2(`NUM_BANKS)-1:0] bank_idx_t;

  // Word index inside one bank
  typedef logic [$clog2(`BANK_WORDS)-1:0] word_off_t;

endpackage

//--- verilog/mcu_irq_pkg.sv
// ****************************************
// Interrupt vector and source types
// ****************************************
`include "mcu_consts.svh"

package mcu_irq_pkg;

  // Vector seen by the core
  typedef logic [31:0] irq_vec_t;

  typedef logic [`NUM_FAST_IRQ-1:0] fast_irq_t;

  // Index of one vector bit
  typedef logic [4:0] irq_id_t;

  typedef logic [`NUM_GPIO_IRQ-1:0] gpio_irq_t;

  // Timer 0 goes to the standard line, the rest to the fast field
  typedef logic [3:0] timer_irq_t;

endpackage

//--- verilog/bank_decoder.sv
// ****************************************
// Bank decoder: splits a bus request
// into bank select and word offset
// ****************************************
`timescale 1ns/1ps
`include "mcu_consts.svh"

module bank_decoder (
  input  logic                   req_i,
  input  logic                   we_i,
  input  mcu_bus_pkg::addr_t     addr_i,
  input  mcu_bus_pkg::be_t       be_i,
  input  mcu_bus_pkg::data_t     wdata_i,
  output logic [`NUM_BANKS-1:0]  bank_req_o,
  output mcu_bus_pkg::bank_idx_t bank_sel_o,
  output mcu_bus_pkg::word_off_t off_o,
  output logic                   we_o,
  output mcu_bus_pkg::be_t       be_o,
  output mcu_bus_pkg::data_t     wdata_o
);

  import mcu_bus_pkg::*;

  localparam int unsigned OFF_LSB  = 2;
  localparam int unsigned OFF_W    = $bits(word_off_t);
  localparam int unsigned BANK_LSB = OFF_LSB + OFF_W;
  localparam int unsigned BANK_W   = $bits(bank_idx_t);

  // Upper address bits are dropped, so the map aliases every 1 KiB
  assign off_o      = addr_i[OFF_LSB +: OFF_W];
  assign bank_sel_o = addr_i[BANK_LSB +: BANK_W];

  // One-hot request to the addressed bank
  always_comb begin
    bank_req_o = '0;
    if (req_i) begin
      bank_req_o[bank_sel_o] = 1'b1;
    end
  end

  // Write controls go to every bank, only the selected one acts
  assign we_o    = we_i;
  assign be_o    = be_i;
  assign wdata_o = wdata_i;

endmodule

//--- verilog/sram_bank.sv
// ****************************************
// Single RAM bank with byte writes
// ****************************************
`timescale 1ns/1ps
`include "mcu_consts.svh"

module sram_bank (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  mcu_bus_pkg::word_off_t off_i,
  input  mcu_bus_pkg::be_t       be_i,
  input  mcu_bus_pkg::data_t     wdata_i,
  output logic                   rvalid_o,
  output mcu_bus_pkg::data_t     rdata_o
);

  import mcu_bus_pkg::*;

  localparam int unsigned BYTE_W = `DATA_WIDTH / `BE_WIDTH;

  data_t mem [`BANK_WORDS];

  // Response valid follows every request by one cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < `BE_WIDTH; b++) begin
          if (be_i[b]) begin
            mem[off_i][b*BYTE_W +: BYTE_W] <= wdata_i[b*BYTE_W +: BYTE_W];
          end
        end
        // Writes answer with zero data
        rdata_o <= '0;
      end else begin
        rdata_o <= mem[off_i];
      end
    end
  end

endmodule

//--- verilog/bank_resp_mux.sv
// ****************************************
// Response mux for the RAM banks
// ****************************************
`timescale 1ns/1ps
`include "mcu_consts.svh"

module bank_resp_mux (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_i,
  input  mcu_bus_pkg::bank_idx_t sel_i,
  input  logic [`NUM_BANKS-1:0]  bank_rvalid_i,
  input  mcu_bus_pkg::data_t     bank_rdata_i [`NUM_BANKS],
  output logic                   rvalid_o,
  output mcu_bus_pkg::data_t     rdata_o
);

  import mcu_bus_pkg::*;

  // Bank that owns the response in the next cycle
  bank_idx_t sel_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_q <= '0;
    end else if (req_i) begin
      sel_q <= sel_i;
    end
  end

  // Only the remembered bank is forwarded, so back-to-back
  // requests to different banks come back in order
  assign rvalid_o = bank_rvalid_i[sel_q];
  assign rdata_o  = bank_rdata_i[sel_q];

endmodule

//--- verilog/irq_vector_builder.sv
// ****************************************
// Interrupt vector assembly and
// highest pending id
// ****************************************
`timescale 1ns/1ps
`include "mcu_consts.svh"

module irq_vector_builder (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    irq_software_i,
  input  logic                    irq_external_i,
  input  mcu_irq_pkg::timer_irq_t timer_irq_i,
  input  logic                    dma_done_irq_i,
  input  logic                    spi_irq_i,
  input  logic                    spi_flash_irq_i,
  input  mcu_irq_pkg::gpio_irq_t  gpio_irq_i,
  output mcu_irq_pkg::irq_vec_t   irq_o,
  output mcu_irq_pkg::irq_id_t    irq_id_o,
  output logic                    irq_valid_o
);

  import mcu_irq_pkg::*;

  fast_irq_t fast_irq;
  irq_vec_t  irq_d;

  // Fast field, top bit unused
  assign fast_irq = {
    1'b0,
    gpio_irq_i,
    spi_flash_irq_i,
    spi_irq_i,
    dma_done_irq_i,
    timer_irq_i[3],
    timer_irq_i[2],
    timer_irq_i[1]
  };

  always_comb begin
    irq_d                                    = '0;
    irq_d[`IRQ_SOFTWARE_BIT]                 = irq_software_i;
    irq_d[`IRQ_TIMER_BIT]                    = timer_irq_i[0];
    irq_d[`IRQ_EXTERNAL_BIT]                 = irq_external_i;
    irq_d[`IRQ_FAST_LSB +: `NUM_FAST_IRQ]    = fast_irq;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_o <= '0;
    end else begin
      irq_o <= irq_d;
    end
  end

  // Later hits overwrite earlier ones, the highest bit wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < $bits(irq_vec_t); i++) begin
      if (irq_o[i]) begin
        irq_id_o = irq_id_t'(i);
      end
    end
  end

  assign irq_valid_o = |irq_o;

endmodule

//--- verilog/mini_mcu_top.sv
// ****************************************
// MCU slice: banked RAM and interrupt
// vector assembly
// ****************************************
`timescale 1ns/1ps
`include "mcu_consts.svh"

module mini_mcu_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  input  logic                    bus_req_i,
  input  logic                    bus_we_i,
  input  mcu_bus_pkg::addr_t      bus_addr_i,
  input  mcu_bus_pkg::be_t        bus_be_i,
  input  mcu_bus_pkg::data_t      bus_wdata_i,
  output logic                    bus_gnt_o,
  output logic                    bus_rvalid_o,
  output mcu_bus_pkg::data_t      bus_rdata_o,

  input  logic                    irq_software_i,
  input  logic                    irq_external_i,
  input  mcu_irq_pkg::timer_irq_t timer_irq_i,
  input  logic                    dma_done_irq_i,
  input  logic                    spi_irq_i,
  input  logic                    spi_flash_irq_i,
  input  mcu_irq_pkg::gpio_irq_t  gpio_irq_i,
  output mcu_irq_pkg::irq_vec_t   irq_o,
  output mcu_irq_pkg::irq_id_t    irq_id_o,
  output logic                    irq_valid_o
);

  import mcu_bus_pkg::*;

  // Decoder to banks
  logic [`NUM_BANKS-1:0] bank_req;
  logic                  bank_we;
  be_t                   bank_be;
  word_off_t             bank_off;
  data_t                 bank_wdata;
  bank_idx_t             bank_sel;

  // Banks to response mux
  logic [`NUM_BANKS-1:0] bank_rvalid;
  data_t                 bank_rdata [`NUM_BANKS];

  // No back-pressure on this bus
  assign bus_gnt_o = bus_req_i;

  bank_decoder u_bank_decoder (
    .req_i      (bus_req_i),
    .we_i       (bus_we_i),
    .addr_i     (bus_addr_i),
    .be_i       (bus_be_i),
    .wdata_i    (bus_wdata_i),
    .bank_req_o (bank_req),
    .bank_sel_o (bank_sel),
    .off_o      (bank_off),
    .we_o       (bank_we),
    .be_o       (bank_be),
    .wdata_o    (bank_wdata)
  );

  for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
    sram_bank u_bank (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (bank_req[i]),
      .we_i     (bank_we),
      .off_i    (bank_off),
      .be_i     (bank_be),
      .wdata_i  (bank_wdata),
      .rvalid_o (bank_rvalid[i]),
      .rdata_o  (bank_rdata[i])
    );
  end

  bank_resp_mux u_bank_resp_mux (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (bus_req_i),
    .sel_i         (bank_sel),
    .bank_rvalid_i (bank_rvalid),
    .bank_rdata_i  (bank_rdata),
    .rvalid_o      (bus_rvalid_o),
    .rdata_o       (bus_rdata_o)
  );

  irq_vector_builder u_irq_vector_builder (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .irq_software_i  (irq_software_i),
    .irq_external_i  (irq_external_i),
    .timer_irq_i     (timer_irq_i),
    .dma_done_irq_i  (dma_done_irq_i),
    .spi_irq_i       (spi_irq_i),
    .spi_flash_irq_i (spi_flash_irq_i),
    .gpio_irq_i      (gpio_irq_i),
    .irq_o           (irq_o),
    .irq_id_o        (irq_id_o),
    .irq_valid_o     (irq_valid_o)
  );

endmodule

//--- verification/mini_mcu_tb.sv
// ****************************************
// Testbench for the MCU slice with banked
// RAM traffic and interrupt vector checks
// ****************************************
`timescale 1ns/1ps
`include "mcu_consts.svh"

module mini_mcu_tb;

  import mcu_bus_pkg::*;
  import mcu_irq_pkg::*;

  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES  = 16;

  localparam logic [1:0] OP_IDLE = 2'd0;
  localparam logic [1:0] OP_WR   = 2'd1;
  localparam logic [1:0] OP_RD   = 2'd2;
  localparam logic [1:0] OP_IRQ  = 2'd3;

  // Source bits inside the data column of an interrupt step
  localparam int SRC_SW    = 0;
  localparam int SRC_EXT   = 1;
  localparam int SRC_TIMER = 2;
  localparam int SRC_DMA   = 6;
  localparam int SRC_SPI   = 7;
  localparam int SRC_FLASH = 8;
  localparam int SRC_GPIO  = 9;

  typedef struct packed {
    logic [1:0] op;
    addr_t      addr;
    be_t        be;
    data_t      data;
    logic       rnd;
  } stim_t;

  logic       clk;
  logic       rst_n;
  logic       bus_req;
  logic       bus_we;
  addr_t      bus_addr;
  be_t        bus_be;
  data_t      bus_wdata;
  logic       bus_gnt;
  logic       bus_rvalid;
  data_t      bus_rdata;
  logic       irq_software;
  logic       irq_external;
  timer_irq_t timer_irq;
  logic       dma_done_irq;
  logic       spi_irq;
  logic       spi_flash_irq;
  gpio_irq_t  gpio_irq;
  irq_vec_t   irq_vec;
  irq_id_t    irq_id;
  logic       irq_valid;

  stim_t       stim_q[$];
  logic        table_ready;
  int          cur_step;
  logic [31:0] lfsr_state;
  data_t       ref_mem [`NUM_BANKS * `BANK_WORDS];

  // Expected response of the step accepted at the last edge
  logic     exp_rvalid;
  data_t    exp_rdata;
  irq_vec_t exp_irq;
  logic     next_rvalid;
  data_t    next_rdata;
  irq_vec_t next_irq;

  mini_mcu_top u_dut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .bus_req_i       (bus_req),
    .bus_we_i        (bus_we),
    .bus_addr_i      (bus_addr),
    .bus_be_i        (bus_be),
    .bus_wdata_i     (bus_wdata),
    .bus_gnt_o       (bus_gnt),
    .bus_rvalid_o    (bus_rvalid),
    .bus_rdata_o     (bus_rdata),
    .irq_software_i  (irq_software),
    .irq_external_i  (irq_external),
    .timer_irq_i     (timer_irq),
    .dma_done_irq_i  (dma_done_irq),
    .spi_irq_i       (spi_irq),
    .spi_flash_irq_i (spi_flash_irq),
    .gpio_irq_i      (gpio_irq),
    .irq_o           (irq_vec),
    .irq_id_o        (irq_id),
    .irq_valid_o     (irq_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hA300_0000;
    end
    return s >> 1;
  endfunction

  // One LFSR step per data bit
  task automatic random_word(output data_t w);
    for (int k = 0; k < `DATA_WIDTH; k++) begin
      w[k] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Flat index of bank and offset per the address map
  function automatic int ref_index(input addr_t addr);
    logic [31:0] word_addr;
    int          bank;
    int          off;
    word_addr = addr >> 2;
    bank = int'((word_addr / `BANK_WORDS) % `NUM_BANKS);
    off  = int'(word_addr % `BANK_WORDS);
    return bank * `BANK_WORDS + off;
  endfunction

  function automatic irq_vec_t model_vector(input logic [31:0] src);
    irq_vec_t v;
    v = '0;
    v[`IRQ_SOFTWARE_BIT]   = src[SRC_SW];
    v[`IRQ_TIMER_BIT]      = src[SRC_TIMER];
    v[`IRQ_EXTERNAL_BIT]   = src[SRC_EXT];
    v[`IRQ_FAST_LSB + 0]   = src[SRC_TIMER + 1];
    v[`IRQ_FAST_LSB + 1]   = src[SRC_TIMER + 2];
    v[`IRQ_FAST_LSB + 2]   = src[SRC_TIMER + 3];
    v[`IRQ_FAST_LSB + 3]   = src[SRC_DMA];
    v[`IRQ_FAST_LSB + 4]   = src[SRC_SPI];
    v[`IRQ_FAST_LSB + 5]   = src[SRC_FLASH];
    for (int g = 0; g < `NUM_GPIO_IRQ; g++) begin
      v[`IRQ_FAST_LSB + 6 + g] = src[SRC_GPIO + g];
    end
    return v;
  endfunction

  // Scan down from the top so the first hit wins
  function automatic irq_id_t model_highest(input irq_vec_t v);
    for (int k = 31; k >= 0; k--) begin
      if (v[k]) begin
        return irq_id_t'(k);
      end
    end
    return '0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL step %0d %s: got 0x%h expected 0x%h", cur_step, name, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic add_step(input logic [1:0] op, input addr_t addr, input be_t be,
                          input data_t data, input logic rnd);
    stim_t s;
    s.op   = op;
    s.addr = addr;
    s.be   = be;
    s.data = data;
    s.rnd  = rnd;
    stim_q.push_back(s);
  endtask

  task automatic drive_sources(input logic [31:0] src);
    irq_software  = src[SRC_SW];
    irq_external  = src[SRC_EXT];
    timer_irq     = src[SRC_TIMER +: 4];
    dma_done_irq  = src[SRC_DMA];
    spi_irq       = src[SRC_SPI];
    spi_flash_irq = src[SRC_FLASH];
    gpio_irq      = src[SRC_GPIO +: `NUM_GPIO_IRQ];
  endtask

  task automatic apply_step(input stim_t s);
    data_t wdata;
    int    idx;
    wdata = s.data;
    if (s.rnd) begin
      random_word(wdata);
    end
    bus_req   = (s.op == OP_WR) || (s.op == OP_RD);
    bus_we    = (s.op == OP_WR);
    bus_addr  = s.addr;
    bus_be    = s.be;
    bus_wdata = wdata;
    drive_sources((s.op == OP_IRQ) ? s.data : 32'h0);
    next_rvalid = bus_req;
    next_rdata  = '0;
    next_irq    = model_vector((s.op == OP_IRQ) ? s.data : 32'h0);
    idx = ref_index(s.addr);
    if (s.op == OP_WR) begin
      for (int b = 0; b < `BE_WIDTH; b++) begin
        if (s.be[b]) begin
          ref_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end else if (s.op == OP_RD) begin
      next_rdata = ref_mem[idx];
    end
  endtask

  task automatic check_response();
    check_value("bus_rvalid_o", 32'(bus_rvalid), 32'(exp_rvalid));
    if (exp_rvalid) begin
      check_value("bus_rdata_o", bus_rdata, exp_rdata);
    end
    check_value("irq_o", irq_vec, exp_irq);
    check_value("irq_id_o", 32'(irq_id), 32'(model_highest(exp_irq)));
    check_value("irq_valid_o", 32'(irq_valid), 32'(|exp_irq));
    check_value("bus_gnt_o", 32'(bus_gnt), 32'(bus_req));
  endtask

  task automatic build_table();
    // One write and one read per bank
    add_step(OP_WR, 32'h0000_0000, 4'hF, 32'h1111_2222, 1'b0);
    add_step(OP_RD, 32'h0000_0000, 4'hF, 32'h0, 1'b0);
    add_step(OP_WR, 32'h0000_0104, 4'hF, 32'h0, 1'b1);
    add_step(OP_RD, 32'h0000_0104, 4'hF, 32'h0, 1'b0);
    add_step(OP_WR, 32'h0000_0208, 4'hF, 32'hA5A5_5A5A, 1'b0);
    add_step(OP_RD, 32'h0000_0208, 4'hF, 32'h0, 1'b0);
    add_step(OP_WR, 32'h0000_03FC, 4'hF, 32'h0, 1'b1);
    add_step(OP_RD, 32'h0000_03FC, 4'hF, 32'h0, 1'b0);
    add_step(OP_IDLE, 32'h0, 4'h0, 32'h0, 1'b0);
    // Partial writes, then aliased reads
    add_step(OP_WR, 32'h0000_0000, 4'b0101, 32'hDEAD_BEEF, 1'b0);
    add_step(OP_RD, 32'h0000_0000, 4'hF, 32'h0, 1'b0);
    add_step(OP_WR, 32'h0000_0208, 4'b1000, 32'h0, 1'b1);
    add_step(OP_RD, 32'h0000_0208, 4'hF, 32'h0, 1'b0);
    add_step(OP_RD, 32'h0000_0400, 4'hF, 32'h0, 1'b0);
    add_step(OP_RD, 32'h0000_1608, 4'hF, 32'h0, 1'b0);
    add_step(OP_RD, 32'hFFFF_FFFC, 4'hF, 32'h0, 1'b0);
    add_step(OP_IDLE, 32'h0, 4'h0, 32'h0, 1'b0);
    // Back-to-back traffic hopping between banks
    add_step(OP_WR, 32'h0000_010C, 4'hF, 32'h0, 1'b1);
    add_step(OP_WR, 32'h0000_030C, 4'hF, 32'h0, 1'b1);
    add_step(OP_RD, 32'h0000_010C, 4'hF, 32'h0, 1'b0);
    add_step(OP_RD, 32'h0000_030C, 4'hF, 32'h0, 1'b0);
    add_step(OP_RD, 32'h0000_0104, 4'hF, 32'h0, 1'b0);
    add_step(OP_RD, 32'h0000_0000, 4'hF, 32'h0, 1'b0);
    add_step(OP_RD, 32'h0000_03FC, 4'hF, 32'h0, 1'b0);
    add_step(OP_RD, 32'h0000_0208, 4'hF, 32'h0, 1'b0);
    add_step(OP_IDLE, 32'h0, 4'h0, 32'h0, 1'b0);
    // Each interrupt source alone
    for (int k = 0; k < SRC_GPIO + `NUM_GPIO_IRQ; k++) begin
      add_step(OP_IRQ, 32'h0, 4'h0, 32'h1 << k, 1'b0);
    end
    // Mixed sources for priority
    add_step(OP_IRQ, 32'h0, 4'h0, 32'h0000_0003, 1'b0);
    add_step(OP_IRQ, 32'h0, 4'h0, 32'h0000_000C, 1'b0);
    add_step(OP_IRQ, 32'h0, 4'h0, 32'h0000_0105, 1'b0);
    add_step(OP_IRQ, 32'h0, 4'h0, 32'h0000_0041, 1'b0);
    add_step(OP_IRQ, 32'h0, 4'h0, 32'h0001_FFFF, 1'b0);
    add_step(OP_IRQ, 32'h0, 4'h0, 32'h0000_0000, 1'b0);
    add_step(OP_IDLE, 32'h0, 4'h0, 32'h0, 1'b0);
  endtask

  initial begin
    wait (table_ready === 1'b1);
    #((stim_q.size() + 100) * CLK_PERIOD_NS);
    $display("Watchdog expired before the stimulus table finished");
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    rst_n      = 1'b0;
    // Active reads and sources that the registers must ignore in reset
    bus_req    = 1'b1;
    bus_we     = 1'b0;
    bus_addr   = '0;
    bus_be     = '0;
    bus_wdata  = '0;
    drive_sources(32'h0001_FFFF);
    lfsr_state = 32'hb292;
    cur_step   = -1;
    exp_rvalid = 1'b0;
    exp_rdata  = '0;
    exp_irq    = '0;
    build_table();
    table_ready = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    #0.5;
    rst_n   = 1'b1;
    bus_req = 1'b0;
    drive_sources(32'h0);
    @(negedge clk);
    check_response();

    for (int i = 0; i <= stim_q.size(); i++) begin
      @(posedge clk);
      #0.5;
      if (i < stim_q.size()) begin
        apply_step(stim_q[i]);
      end else begin
        apply_step('0);
      end
      @(negedge clk);
      check_response();
      cur_step   = i;
      exp_rvalid = next_rvalid;
      exp_rdata  = next_rdata;
      exp_irq    = next_irq;
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
verilog/mcu_bus_pkg.sv
verilog/mcu_irq_pkg.sv
verilog/bank_decoder.sv
verilog/sram_bank.sv
verilog/bank_resp_mux.sv
verilog/irq_vector_builder.sv
verilog/mini_mcu_top.sv
verification/mini_mcu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MCU slice testbench with Verilator.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing -f vlog.f --top-module mini_mcu_tb \
  --Mdir obj_dir -o mini_mcu_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/mini_mcu_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit "$status"
fi

echo "Simulation exited cleanly"
exit 0
